/* logic/dll_rx_pkg.sv */
/*
 * Shared sizes, word types, FSM encodings and CRC helpers for the PCIe
 * data link layer receive path. Modules import it inside their bodies.
 */
package dll_rx_pkg;

  localparam int WORD_W        = 32;
  localparam int SEQ_W         = 12;
  localparam int LEN_W         = 4;
  localparam int CRC16_W       = 16;
  localparam int MAX_TLP_WORDS = 8;
  // one extra word per slot so the LCRC lands inside the slot
  localparam int SLOT_WORDS    = MAX_TLP_WORDS + 1;
  localparam int RX_SLOTS      = 4;
  localparam int BUF_ADDR_W    = $clog2(RX_SLOTS * SLOT_WORDS);
  localparam int SLOT_IDX_W    = $clog2(RX_SLOTS);
  localparam int SLOT_PTR_W    = SLOT_IDX_W + 1;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [SEQ_W-1:0]      seq_t;
  typedef logic [LEN_W-1:0]      len_t;
  typedef logic [CRC16_W-1:0]    crc16_t;
  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
  typedef logic [SLOT_PTR_W-1:0] slot_ptr_t;

  localparam logic [7:0] DLLP_ACK      = 8'h00;
  localparam logic [7:0] DLLP_NAK      = 8'h10;
  localparam word_t      LCRC_POLY     = 32'h04C1_1DB7;
  localparam crc16_t     DLLP_CRC_POLY = 16'h100B;

  typedef enum logic [1:0] {
    CHK_IDLE,
    CHK_FRAME,
    CHK_VERDICT,
    CHK_WAIT_ACK
  } chk_state_e;

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_PRIME,
    OUT_STREAM
  } out_state_e;

  // one word into the running LCRC, msb first
  function automatic word_t lcrc_next(input word_t crc, input word_t data);
    word_t c;
    logic  fb;
    c = crc;
    for (int i = WORD_W - 1; i >= 0; i--) begin
      fb = c[WORD_W-1] ^ data[i];
      c  = {c[WORD_W-2:0], 1'b0};
      if (fb) begin
        c = c ^ LCRC_POLY;
      end
    end
    return c;
  endfunction

  // full CRC-16 of one DLLP word, seeded with ones and inverted at the end
  function automatic crc16_t dllp_crc16(input word_t data);
    crc16_t c;
    logic   fb;
    c = '1;
    for (int i = WORD_W - 1; i >= 0; i--) begin
      fb = c[CRC16_W-1] ^ data[i];
      c  = {c[CRC16_W-2:0], 1'b0};
      if (fb) begin
        c = c ^ DLLP_CRC_POLY;
      end
    end
    return ~c;
  endfunction

endpackage

/* logic/word_stream_if.sv */
/*
 * Word stream with data, last and a valid/ready handshake, used between
 * stages inside the receive path. The source side holds data until taken.
 */
`timescale 1ns/1ps

interface word_stream_if;
  import dll_rx_pkg::*;

  word_t data;
  logic  last;
  logic  valid;
  logic  ready;

  modport src (
    output data, last, valid,
    input  ready
  );

  modport snk (
    input  data, last, valid,
    output ready
  );

endinterface

/* logic/rx_skid_buffer.sv */
/*
 * Two-entry skid buffer on the receive input. Ready toward the link is a
 * register, and a beat caught while downstream stalls goes to the spill slot.
 */
`timescale 1ns/1ps

module rx_skid_buffer (
  input  logic              clk_i,
  input  logic              rst_i,
  input  dll_rx_pkg::word_t in_data_i,
  input  logic              in_last_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  word_stream_if.src        out
);
  import dll_rx_pkg::*;

  word_t main_data_q;
  word_t spill_data_q;
  logic  main_last_q;
  logic  spill_last_q;
  logic  main_valid_q;
  logic  spill_valid_q;
  logic  ready_q;
  logic  in_fire;
  logic  load_main;

  assign in_fire   = in_valid_i && ready_q;
  // main register free or being drained this cycle
  assign load_main = out.ready || !main_valid_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else if (load_main) begin
      main_valid_q  <= spill_valid_q || in_fire;
      spill_valid_q <= 1'b0;
      ready_q       <= 1'b1;
    end else if (in_fire) begin
      spill_valid_q <= 1'b1;
      ready_q       <= 1'b0;
    end else begin
      ready_q <= !spill_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      main_data_q <= spill_valid_q ? spill_data_q : in_data_i;
      main_last_q <= spill_valid_q ? spill_last_q : in_last_i;
    end else if (in_fire) begin
      spill_data_q <= in_data_i;
      spill_last_q <= in_last_i;
    end
  end

  assign in_ready_o = ready_q;
  assign out.data   = main_data_q;
  assign out.last   = main_last_q;
  assign out.valid  = main_valid_q;

endmodule

/* logic/lcrc_frame_check.sv */
/*
 * Frame checker. Takes the sequence word, the TLP words and the LCRC word,
 * writes everything after word0 into the tail slot and gives its verdict
 * one cycle after the LCRC beat as a commit plus an Ack or Nak request.
 */
`timescale 1ns/1ps

module lcrc_frame_check (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  link_active_i,
  word_stream_if.snk            in,
  input  logic                  buf_full_i,
  input  dll_rx_pkg::buf_addr_t tail_base_i,
  output logic                  wr_en_o,
  output dll_rx_pkg::buf_addr_t wr_addr_o,
  output dll_rx_pkg::word_t     wr_data_o,
  output logic                  commit_o,
  output dll_rx_pkg::len_t      commit_len_o,
  output logic                  ack_req_o,
  output logic                  ack_nak_o,
  output dll_rx_pkg::seq_t      ack_seq_o,
  input  logic                  ack_done_i
);
  import dll_rx_pkg::*;

  chk_state_e state_q;
  seq_t       exp_seq_q;
  seq_t       frame_seq_q;
  seq_t       ack_seq_q;
  word_t      crc_q;
  len_t       cnt_q;
  logic       too_long_q;
  logic       good_q;
  logic       nak_q;
  logic       ack_req_q;
  logic       beat;
  logic       frame_end;
  logic       verdict_good;

  // new frames only start with the link up and a free slot
  assign in.ready = (state_q == CHK_IDLE) ? (link_active_i && !buf_full_i)
                                          : (state_q == CHK_FRAME);
  assign beat      = in.valid && in.ready;
  assign frame_end = beat && in.last;

  // a last flag on word0 leaves no TLP, so it always fails
  assign verdict_good = (state_q == CHK_FRAME) && (in.data == ~crc_q) &&
                        (frame_seq_q == exp_seq_q) && (cnt_q != '0) && !too_long_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= CHK_IDLE;
      exp_seq_q  <= '0;
      ack_seq_q  <= '0;
      cnt_q      <= '0;
      too_long_q <= 1'b0;
      good_q     <= 1'b0;
      nak_q      <= 1'b0;
      ack_req_q  <= 1'b0;
    end else if (frame_end) begin
      good_q    <= verdict_good;
      nak_q     <= !verdict_good;
      // Nak names the last sequence number that was accepted
      ack_seq_q <= verdict_good ? frame_seq_q : exp_seq_q - seq_t'(1);
      ack_req_q <= 1'b1;
      state_q   <= CHK_VERDICT;
    end else begin
      case (state_q)
        CHK_IDLE: begin
          if (beat) begin
            cnt_q      <= '0;
            too_long_q <= 1'b0;
            state_q    <= CHK_FRAME;
          end
        end
        CHK_FRAME: begin
          if (beat) begin
            if (cnt_q == len_t'(MAX_TLP_WORDS)) begin
              too_long_q <= 1'b1;
            end else begin
              cnt_q <= cnt_q + len_t'(1);
            end
          end
        end
        CHK_VERDICT: begin
          if (good_q) begin
            exp_seq_q <= exp_seq_q + seq_t'(1);
          end
          state_q <= CHK_WAIT_ACK;
        end
        CHK_WAIT_ACK: begin
          if (ack_done_i) begin
            ack_req_q <= 1'b0;
            state_q   <= CHK_IDLE;
          end
        end
        default: state_q <= CHK_IDLE;
      endcase
    end
  end

  // running LCRC covers word0 and every TLP word, not the LCRC itself
  always_ff @(posedge clk_i) begin
    if (beat) begin
      if (state_q == CHK_IDLE) begin
        frame_seq_q <= in.data[SEQ_W-1:0];
        crc_q       <= lcrc_next('1, in.data);
      end else if (!in.last) begin
        crc_q <= lcrc_next(crc_q, in.data);
      end
    end
  end

  assign wr_en_o      = beat && (state_q == CHK_FRAME) && !too_long_q;
  assign wr_addr_o    = tail_base_i + buf_addr_t'(cnt_q);
  assign wr_data_o    = in.data;
  assign commit_o     = (state_q == CHK_VERDICT) && good_q;
  assign commit_len_o = cnt_q;
  assign ack_req_o    = ack_req_q;
  assign ack_nak_o    = nak_q;
  assign ack_seq_o    = ack_seq_q;

endmodule

/* logic/rx_tlp_buffer.sv */
/*
 * Receive buffer as a ring of fixed-size slots in one dual-port RAM.
 * Commit advances the tail slot and release frees the head slot.
 */
`timescale 1ns/1ps

module rx_tlp_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  wr_en_i,
  input  dll_rx_pkg::buf_addr_t wr_addr_i,
  input  dll_rx_pkg::word_t     wr_data_i,
  input  logic                  commit_i,
  input  dll_rx_pkg::len_t      commit_len_i,
  output logic                  buf_full_o,
  output dll_rx_pkg::buf_addr_t tail_base_o,
  input  dll_rx_pkg::buf_addr_t rd_addr_i,
  output dll_rx_pkg::word_t     rd_data_o,
  input  logic                  release_i,
  output logic                  empty_o,
  output dll_rx_pkg::len_t      head_len_o,
  output dll_rx_pkg::buf_addr_t head_base_o
);
  import dll_rx_pkg::*;

  word_t                 mem [RX_SLOTS*SLOT_WORDS];
  len_t                  len_mem [RX_SLOTS];
  slot_ptr_t             head_q;
  slot_ptr_t             tail_q;
  logic [SLOT_IDX_W-1:0] head_idx;
  logic [SLOT_IDX_W-1:0] tail_idx;

  function automatic buf_addr_t slot_base(input logic [SLOT_IDX_W-1:0] idx);
    return buf_addr_t'(idx) * buf_addr_t'(SLOT_WORDS);
  endfunction

  assign head_idx = head_q[SLOT_IDX_W-1:0];
  assign tail_idx = tail_q[SLOT_IDX_W-1:0];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (commit_i) begin
        tail_q <= tail_q + slot_ptr_t'(1);
      end
      if (release_i) begin
        head_q <= head_q + slot_ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    if (commit_i) begin
      len_mem[tail_idx] <= commit_len_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

  // same slot index, wrap bits differ when the ring is full
  assign empty_o     = (head_q == tail_q);
  assign buf_full_o  = (head_q[SLOT_IDX_W] != tail_q[SLOT_IDX_W]) && (head_idx == tail_idx);
  assign head_len_o  = len_mem[head_idx];
  assign head_base_o = slot_base(head_idx);
  assign tail_base_o = slot_base(tail_idx);

endmodule

/* logic/tlp_stream_out.sv */
/*
 * Streams the oldest committed slot to the transaction layer. The RAM is
 * read one word ahead of the output register, and the slot is released
 * once its final word is taken.
 */
`timescale 1ns/1ps

module tlp_stream_out (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  empty_i,
  input  dll_rx_pkg::len_t      head_len_i,
  input  dll_rx_pkg::buf_addr_t head_base_i,
  output dll_rx_pkg::buf_addr_t rd_addr_o,
  input  dll_rx_pkg::word_t     rd_data_i,
  output logic                  release_o,
  output dll_rx_pkg::word_t     tlp_data_o,
  output logic                  tlp_last_o,
  output logic                  tlp_valid_o,
  input  logic                  tlp_ready_i
);
  import dll_rx_pkg::*;

  out_state_e state_q;
  len_t       rd_idx_q;
  len_t       rd_idx_d;
  word_t      data_q;
  logic       last_q;
  logic       valid_q;
  logic       fire;

  assign fire = valid_q && tlp_ready_i;

  // rd_idx_q names the slot word sitting on rd_data_i
  always_comb begin
    rd_idx_d = rd_idx_q;
    case (state_q)
      OUT_IDLE:   rd_idx_d = '0;
      OUT_PRIME:  rd_idx_d = len_t'(1);
      OUT_STREAM: begin
        if (fire) begin
          rd_idx_d = rd_idx_q + len_t'(1);
        end
      end
      default:    rd_idx_d = '0;
    endcase
  end

  assign rd_addr_o = head_base_i + buf_addr_t'(rd_idx_d);
  assign release_o = (state_q == OUT_STREAM) && fire && last_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= OUT_IDLE;
      rd_idx_q <= '0;
      valid_q  <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      rd_idx_q <= rd_idx_d;
      case (state_q)
        OUT_IDLE: begin
          if (!empty_i) begin
            state_q <= OUT_PRIME;
          end
        end
        OUT_PRIME: begin
          valid_q <= 1'b1;
          last_q  <= (head_len_i == len_t'(1));
          state_q <= OUT_STREAM;
        end
        OUT_STREAM: begin
          if (fire && last_q) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            state_q <= OUT_IDLE;
          end else if (fire) begin
            last_q <= ((rd_idx_q + len_t'(1)) == head_len_i);
          end
        end
        default: state_q <= OUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == OUT_PRIME) || ((state_q == OUT_STREAM) && fire)) begin
      data_q <= rd_data_i;
    end
  end

  assign tlp_data_o  = data_q;
  assign tlp_last_o  = last_q;
  assign tlp_valid_o = valid_q;

endmodule

/* logic/ack_dllp_tx.sv */
/*
 * Ack/Nak DLLP sender. Latches the checker's request, builds the DLLP
 * word and its CRC-16, and sends them as a two-beat packet.
 */
`timescale 1ns/1ps

module ack_dllp_tx (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ack_req_i,
  input  logic              ack_nak_i,
  input  dll_rx_pkg::seq_t  ack_seq_i,
  output logic              ack_done_o,
  output dll_rx_pkg::word_t dllp_data_o,
  output logic              dllp_last_o,
  output logic              dllp_valid_o,
  input  logic              dllp_ready_i
);
  import dll_rx_pkg::*;

  word_t  beat1_d;
  word_t  beat1_q;
  crc16_t crc_q;
  logic   valid_q;
  logic   second_q;
  logic   fire;
  logic   take_req;

  // type byte on top, sequence number in the low bits
  assign beat1_d = {(ack_nak_i ? DLLP_NAK : DLLP_ACK), {(WORD_W-8-SEQ_W){1'b0}}, ack_seq_i};

  assign fire       = valid_q && dllp_ready_i;
  assign take_req   = ack_req_i && !valid_q;
  assign ack_done_o = fire && second_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q  <= 1'b0;
      second_q <= 1'b0;
    end else if (take_req) begin
      valid_q  <= 1'b1;
      second_q <= 1'b0;
    end else if (fire) begin
      valid_q  <= !second_q;
      second_q <= !second_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_req) begin
      beat1_q <= beat1_d;
      crc_q   <= dllp_crc16(beat1_d);
    end
  end

  assign dllp_data_o  = second_q ? {{(WORD_W-CRC16_W){1'b0}}, crc_q} : beat1_q;
  assign dllp_last_o  = second_q;
  assign dllp_valid_o = valid_q;

endmodule

/* logic/dll_rx_top.sv */
/*
 * Top of the data link layer receive path. Connects the input skid
 * buffer, frame checker, slot buffer, TLP streamer and Ack/Nak sender.
 */
`timescale 1ns/1ps

module dll_rx_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              link_active_i,
  input  dll_rx_pkg::word_t in_data_i,
  input  logic              in_last_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output dll_rx_pkg::word_t tlp_data_o,
  output logic              tlp_last_o,
  output logic              tlp_valid_o,
  input  logic              tlp_ready_i,
  output dll_rx_pkg::word_t dllp_data_o,
  output logic              dllp_last_o,
  output logic              dllp_valid_o,
  input  logic              dllp_ready_i
);
  import dll_rx_pkg::*;

  word_stream_if chk_if ();

  logic      skid_valid;
  logic      skid_ready;
  logic      wr_en;
  logic      commit;
  logic      buf_full;
  logic      buf_empty;
  logic      buf_release;
  logic      ack_req;
  logic      ack_nak;
  logic      ack_done;
  seq_t      ack_seq;
  buf_addr_t wr_addr;
  buf_addr_t tail_base;
  buf_addr_t rd_addr;
  buf_addr_t head_base;
  word_t     wr_data;
  word_t     rd_data;
  len_t      commit_len;
  len_t      head_len;

  // no beat crosses the input while the link is down
  assign skid_valid = in_valid_i && link_active_i;
  assign in_ready_o = skid_ready && link_active_i;

  rx_skid_buffer u_skid (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_data_i  (in_data_i),
    .in_last_i  (in_last_i),
    .in_valid_i (skid_valid),
    .in_ready_o (skid_ready),
    .out        (chk_if.src)
  );

  lcrc_frame_check u_check (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .link_active_i (link_active_i),
    .in            (chk_if.snk),
    .buf_full_i    (buf_full),
    .tail_base_i   (tail_base),
    .wr_en_o       (wr_en),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .commit_o      (commit),
    .commit_len_o  (commit_len),
    .ack_req_o     (ack_req),
    .ack_nak_o     (ack_nak),
    .ack_seq_o     (ack_seq),
    .ack_done_i    (ack_done)
  );

  rx_tlp_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .commit_i     (commit),
    .commit_len_i (commit_len),
    .buf_full_o   (buf_full),
    .tail_base_o  (tail_base),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .release_i    (buf_release),
    .empty_o      (buf_empty),
    .head_len_o   (head_len),
    .head_base_o  (head_base)
  );

  tlp_stream_out u_stream (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .empty_i     (buf_empty),
    .head_len_i  (head_len),
    .head_base_i (head_base),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .release_o   (buf_release),
    .tlp_data_o  (tlp_data_o),
    .tlp_last_o  (tlp_last_o),
    .tlp_valid_o (tlp_valid_o),
    .tlp_ready_i (tlp_ready_i)
  );

  ack_dllp_tx u_ack (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ack_req_i    (ack_req),
    .ack_nak_i    (ack_nak),
    .ack_seq_i    (ack_seq),
    .ack_done_o   (ack_done),
    .dllp_data_o  (dllp_data_o),
    .dllp_last_o  (dllp_last_o),
    .dllp_valid_o (dllp_valid_o),
    .dllp_ready_i (dllp_ready_i)
  );

endmodule

/* testbench/tb_dll_rx.sv */
/*
 * Testbench for the data link layer receive path. Frames from a table are
 * sent through dll_rx_top, and the TLP and Ack/Nak DLLP outputs are
 * checked against scoreboard queues built from reference CRC models.
 */
`timescale 1ns/1ps

module tb_dll_rx;

  localparam int          CLK_HALF     = 4;
  localparam int          LINK_DOWN_N  = 20;
  localparam int          STALL_LIMIT  = 16;
  localparam int          HOLD_LIMIT   = 200;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED    = 32'd20217;
  localparam logic [7:0]  ACK_TYPE     = 8'h00;
  localparam logic [7:0]  NAK_TYPE     = 8'h10;
  localparam logic [1:0]  RDY_ON       = 2'd0;
  localparam logic [1:0]  RDY_RAND     = 2'd1;
  localparam logic [1:0]  RDY_HOLD     = 2'd2;
  localparam logic        ACK          = 1'b0;
  localparam logic        NAK          = 1'b1;

  typedef struct packed {
    logic [11:0] seq;
    logic [3:0]  len;
    logic        corrupt;
    logic        nak;
    logic [1:0]  mode;
  } frame_row_t;

  logic        clk_i;
  logic        rst_i;
  logic        link_active_i;
  logic [31:0] in_data_i;
  logic        in_last_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] tlp_data_o;
  logic        tlp_last_o;
  logic        tlp_valid_o;
  logic        tlp_ready_i;
  logic [31:0] dllp_data_o;
  logic        dllp_last_o;
  logic        dllp_valid_o;
  logic        dllp_ready_i;

  frame_row_t  frame_tab[$];
  logic [32:0] exp_tlp_q[$];
  int          exp_tlp_row_q[$];
  logic [32:0] exp_dllp_q[$];
  int          exp_dllp_row_q[$];
  logic [31:0] lfsr_q = LFSR_SEED;
  logic [31:0] ready_bits;
  logic [11:0] exp_seq = '0;
  logic [1:0]  ready_mode = RDY_ON;
  int          hold_state = 0;
  int          hold_cycles = 0;
  int          stall_cycles = 0;
  logic        stall_seen = 1'b0;
  int          cycle_count = 0;
  int          cycle_limit = 100000;

  dll_rx_top dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .link_active_i (link_active_i),
    .in_data_i     (in_data_i),
    .in_last_i     (in_last_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .tlp_data_o    (tlp_data_o),
    .tlp_last_o    (tlp_last_o),
    .tlp_valid_o   (tlp_valid_o),
    .tlp_ready_i   (tlp_ready_i),
    .dllp_data_o   (dllp_data_o),
    .dllp_last_o   (dllp_last_o),
    .dllp_valid_o  (dllp_valid_o),
    .dllp_ready_i  (dllp_ready_i)
  );

  initial clk_i = 1'b0;
  always #CLK_HALF clk_i = ~clk_i;

  // right-shifting Galois form
  function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_advance(lfsr_q);
    end
    return v;
  endfunction

  // reference CRC-32 step with poly 04C11DB7 taken msb first
  function automatic logic [31:0] ref_crc32(input logic [31:0] crc, input logic [31:0] w);
    logic [31:0] r;
    r = crc;
    for (int b = 31; b >= 0; b--) begin
      if (r[31] != w[b]) begin
        r = (r << 1) ^ 32'h04C1_1DB7;
      end else begin
        r = r << 1;
      end
    end
    return r;
  endfunction

  // reference DLLP CRC-16 over poly 100B with all-ones seed and final inversion
  function automatic logic [15:0] ref_crc16(input logic [31:0] w);
    logic [15:0] r;
    r = 16'hFFFF;
    for (int b = 31; b >= 0; b--) begin
      if (r[15] != w[b]) begin
        r = (r << 1) ^ 16'h100B;
      end else begin
        r = r << 1;
      end
    end
    return ~r;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic add_row(input int seq, input int len, input logic corrupt,
                         input logic nak, input logic [1:0] mode);
    frame_row_t row;
    row.seq     = 12'(seq);
    row.len     = 4'(len);
    row.corrupt = corrupt;
    row.nak     = nak;
    row.mode    = mode;
    frame_tab.push_back(row);
  endtask

  task automatic build_table();
    // good frame, bad LCRC, wrong sequence then the right one
    add_row(0, 4, 0, ACK, RDY_ON);
    add_row(1, 3, 1, NAK, RDY_ON);
    add_row(5, 2, 0, NAK, RDY_ON);
    add_row(1, 2, 0, ACK, RDY_ON);
    // empty and oversized TLPs
    add_row(2, 0, 0, NAK, RDY_ON);
    add_row(2, 9, 0, NAK, RDY_ON);
    // TLP output held until the buffer fills
    add_row(2, 3, 0, ACK, RDY_HOLD);
    add_row(3, 8, 0, ACK, RDY_HOLD);
    add_row(4, 1, 0, ACK, RDY_HOLD);
    add_row(5, 5, 0, ACK, RDY_HOLD);
    add_row(6, 2, 0, ACK, RDY_HOLD);
    add_row(7, 7, 0, ACK, RDY_HOLD);
    // random back-pressure on both outputs
    add_row(8, 1, 0, ACK, RDY_RAND);
    add_row(9, 8, 0, ACK, RDY_RAND);
    add_row(10, 5, 1, NAK, RDY_RAND);
    add_row(10, 3, 0, ACK, RDY_RAND);
    add_row(11, 7, 0, ACK, RDY_RAND);
    add_row(20, 2, 0, NAK, RDY_RAND);
    add_row(12, 6, 0, ACK, RDY_RAND);
    add_row(13, 8, 1, NAK, RDY_RAND);
    add_row(13, 4, 0, ACK, RDY_RAND);
    add_row(14, 2, 0, ACK, RDY_RAND);
  endtask

  // starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_word(input logic [31:0] data, input logic last);
    in_data_i  = data;
    in_last_i  = last;
    in_valid_i = 1'b1;
    while (!in_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic send_frame(input int r);
    frame_row_t  row;
    logic [31:0] words[$];
    logic [31:0] crc;
    logic [31:0] w;
    logic [31:0] beat1;
    logic [11:0] dseq;
    row   = frame_tab[r];
    w     = take_bits(20);
    w     = {w[19:0], row.seq};
    crc   = ref_crc32(32'hFFFF_FFFF, w);
    words.push_back(w);
    for (int i = 0; i < row.len; i++) begin
      w   = take_bits(32);
      crc = ref_crc32(crc, w);
      words.push_back(w);
      if (row.nak == ACK) begin
        exp_tlp_q.push_back({(i == row.len - 1), w});
        exp_tlp_row_q.push_back(r);
      end
    end
    crc = ~crc;
    if (row.corrupt) begin
      crc = crc ^ 32'h0001_0100;
    end
    words.push_back(crc);
    // Nak reports the last sequence number that was accepted
    if (row.nak == NAK) begin
      dseq  = exp_seq - 12'd1;
      beat1 = {NAK_TYPE, 12'h000, dseq};
    end else begin
      dseq    = row.seq;
      exp_seq = exp_seq + 12'd1;
      beat1   = {ACK_TYPE, 12'h000, dseq};
    end
    exp_dllp_q.push_back({1'b0, beat1});
    exp_dllp_q.push_back({1'b1, 16'h0000, ref_crc16(beat1)});
    exp_dllp_row_q.push_back(r);
    exp_dllp_row_q.push_back(r);
    for (int i = 0; i < words.size(); i++) begin
      send_word(words[i], i == words.size() - 1);
    end
  endtask

  task automatic take_tlp_word();
    logic [32:0] expected;
    int          row;
    if (exp_tlp_q.size() == 0) begin
      fail_run("a TLP word came out while none was expected");
    end else begin
      expected = exp_tlp_q.pop_front();
      row      = exp_tlp_row_q.pop_front();
      expect_equal($sformatf("tlp row %0d", row), 64'(expected),
                   {31'h0, tlp_last_o, tlp_data_o});
    end
  endtask

  task automatic take_dllp_beat();
    logic [32:0] expected;
    int          row;
    if (exp_dllp_q.size() == 0) begin
      fail_run("a DLLP beat came out while none was expected");
    end else begin
      expected = exp_dllp_q.pop_front();
      row      = exp_dllp_row_q.pop_front();
      expect_equal($sformatf("dllp row %0d", row), 64'(expected),
                   {31'h0, dllp_last_o, dllp_data_o});
    end
  endtask

  // output ready patterns change on the falling edge
  always @(negedge clk_i) begin
    if (hold_state == 1) begin
      tlp_ready_i  = 1'b0;
      dllp_ready_i = 1'b1;
    end else if (ready_mode == RDY_RAND) begin
      ready_bits   = take_bits(2);
      tlp_ready_i  = ready_bits[0];
      dllp_ready_i = ready_bits[1];
    end else begin
      tlp_ready_i  = 1'b1;
      dllp_ready_i = 1'b1;
    end
  end

  // scoreboard, full-buffer stall detect and cycle limit
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      fail_run($sformatf("timeout after %0d cycles, the DUT stopped making progress",
                         cycle_count));
    end
    if (!rst_i && tlp_valid_o && tlp_ready_i) begin
      take_tlp_word();
    end
    if (!rst_i && dllp_valid_o && dllp_ready_i) begin
      take_dllp_beat();
    end
    if (hold_state == 1) begin
      hold_cycles = hold_cycles + 1;
      if (in_valid_i && !in_ready_o) begin
        stall_cycles = stall_cycles + 1;
      end else begin
        stall_cycles = 0;
      end
      if (stall_cycles >= STALL_LIMIT) begin
        stall_seen = 1'b1;
        hold_state = 2;
      end else if (hold_cycles >= HOLD_LIMIT) begin
        // hold ends even without a stall so the TLPs still drain
        hold_state = 2;
      end
    end
  end

  initial begin
    int total_words;
    rst_i         = 1'b1;
    link_active_i = 1'b0;
    in_data_i     = '0;
    in_last_i     = 1'b0;
    in_valid_i    = 1'b0;
    tlp_ready_i   = 1'b0;
    dllp_ready_i  = 1'b0;
    build_table();
    total_words = 0;
    foreach (frame_tab[r]) begin
      total_words = total_words + frame_tab[r].len + 2;
    end
    cycle_limit = total_words * 20 + LINK_DOWN_N + HOLD_LIMIT + 40;

    @(negedge clk_i);
    expect_equal("in_ready in reset", 0, in_ready_o);
    expect_equal("tlp_valid in reset", 0, tlp_valid_o);
    expect_equal("dllp_valid in reset", 0, dllp_valid_o);
    @(negedge clk_i);
    rst_i = 1'b0;

    // an offered word must not be taken while the link is down
    in_data_i  = 32'h0000_0000;
    in_last_i  = 1'b1;
    in_valid_i = 1'b1;
    repeat (LINK_DOWN_N) begin
      @(negedge clk_i);
      expect_equal("in_ready link down", 0, in_ready_o);
      expect_equal("tlp_valid link down", 0, tlp_valid_o);
      expect_equal("dllp_valid link down", 0, dllp_valid_o);
    end
    in_valid_i    = 1'b0;
    in_last_i     = 1'b0;
    link_active_i = 1'b1;
    @(negedge clk_i);

    foreach (frame_tab[r]) begin
      ready_mode = frame_tab[r].mode;
      if (frame_tab[r].mode == RDY_HOLD && hold_state == 0) begin
        hold_state = 1;
      end
      send_frame(r);
    end

    while (exp_tlp_q.size() != 0 || exp_dllp_q.size() != 0) begin
      @(negedge clk_i);
    end
    ready_mode = RDY_ON;
    // idle tail where the monitors flag any stray output
    repeat (20) @(negedge clk_i);
    expect_equal("buffer full stall", 1, stall_seen);
    expect_equal("tlp valid at end", 0, tlp_valid_o);
    expect_equal("dllp valid at end", 0, dllp_valid_o);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* project.f */
logic/dll_rx_pkg.sv
logic/word_stream_if.sv
logic/rx_skid_buffer.sv
logic/lcrc_frame_check.sv
logic/rx_tlp_buffer.sv
logic/tlp_stream_out.sv
logic/ack_dllp_tx.sv
logic/dll_rx_top.sv
testbench/tb_dll_rx.sv
